/* all.f */
verilog/rv_pkg.sv
verilog/imm_gen.sv
verilog/inst_decoder.sv
verilog/execute_unit.sv
verilog/branch_unit.sv
verilog/result_stage.sv
verilog/rv32i_exec_slice.sv
testbench/tb_rv32i_exec_slice.sv

/* run.sh */
#!/bin/sh
# build and run the testbench with verilator, then judge the log
verilator --binary --timing --timescale 1ns/1ps -f all.f \
    --top-module tb_rv32i_exec_slice -o tb_sim \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    || { echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "Verification failed" sim.log && exit 1 || grep -q "Verification passed" sim.log

/* testbench/exec_stim.hex */
// valid pc inst rs1_data rs2_data | expected: wb_en wb_addr wb_data next_pc illegal
// valid 0 marks an idle cycle, the other columns are unused there
1 00000100 002081B3 00000005 00000007 1 03 0000000C 00000104 0
1 00000104 402081B3 00000005 00000007 1 03 FFFFFFFE 00000108 0
1 00000108 0020A1B3 FFFFFFF0 00000001 1 03 00000001 0000010C 0
1 0000010C 0020B1B3 FFFFFFF0 00000001 1 03 00000000 00000110 0
1 00000110 4020D1B3 80000000 00000004 1 03 F8000000 00000114 0
1 00000114 0020D1B3 80000000 00000024 1 03 08000000 00000118 0
1 00000118 002091B3 00000003 0000001F 1 03 80000000 0000011C 0
1 0000011C 0020C1B3 F0F0F0F0 FF00FF00 1 03 0FF00FF0 00000120 0
0 00000000 00000000 00000000 00000000 0 00 00000000 00000000 0
1 00000120 0020E1B3 F0F0F0F0 0F000F00 1 03 FFF0FFF0 00000124 0
1 00000124 0020F1B3 F0F0F0F0 FF00FF00 1 03 F000F000 00000128 0
1 00000128 FFB08193 00000003 DEADBEEF 1 03 FFFFFFFE 0000012C 0
1 0000012C FFF0B193 00000010 00000000 1 03 00000001 00000130 0
1 00000130 0F00F193 12345678 00000000 1 03 00000070 00000134 0
1 00000134 8000E193 00000012 00000000 1 03 FFFFF812 00000138 0
1 00000138 5550C193 00000FFF 00000000 1 03 00000AAA 0000013C 0
1 0000013C 00409193 8000000F 00000000 1 03 000000F0 00000140 0
1 00000140 0080D193 87654321 00000000 1 03 00876543 00000144 0
1 00000144 4080D193 87654321 00000000 1 03 FF876543 00000148 0
1 00000148 123452B7 AAAAAAAA 55555555 1 05 12345000 0000014C 0
1 00000150 ABCDE317 AAAAAAAA 55555555 1 06 ABCDE150 00000154 0
1 00000200 00208863 00000042 00000042 0 00 00000000 00000210 0
1 00000204 FE208CE3 00000042 00000043 0 00 00000000 00000208 0
1 00000208 FE209CE3 00000001 00000002 0 00 00000000 00000200 0
1 0000020C 00209863 00000005 00000005 0 00 00000000 00000210 0
1 00000210 0020C863 FFFFFFFF 00000001 0 00 00000000 00000220 0
1 00000214 0020C863 00000001 FFFFFFFF 0 00 00000000 00000218 0
1 00000218 FE20DCE3 00000001 FFFFFFFF 0 00 00000000 00000210 0
1 0000021C 0020D863 FFFFFFFF 00000001 0 00 00000000 00000220 0
1 00000220 0020E863 00000001 FFFFFFFF 0 00 00000000 00000230 0
1 00000224 0020E863 FFFFFFFF 00000001 0 00 00000000 00000228 0
1 00000228 0020F863 FFFFFFFF 00000001 0 00 00000000 00000238 0
1 0000022C 0020F863 00000001 FFFFFFFF 0 00 00000000 00000230 0
0 00000000 00000000 00000000 00000000 0 00 00000000 00000000 0
1 00000300 100000EF 00000000 00000000 1 01 00000304 00000400 0
1 00000304 005083E7 00001000 00000000 1 07 00000308 00001004 0
1 00000308 000001FF 00000001 00000002 0 00 00000000 0000030C 1
1 0000030C 022081B3 00000003 00000004 0 00 00000000 00000310 1
1 00000310 00208033 00000001 00000002 0 00 00000000 00000314 0
0 00000000 00000000 00000000 00000000 0 00 00000000 00000000 0

/* testbench/tb_rv32i_exec_slice.sv */
// tb_rv32i_exec_slice: clock, reset, vector replay from the stim file, output checks, timeout
`default_nettype none
`timescale 1ns/1ps

module tb_rv32i_exec_slice;

    localparam int RESET_CYCLES = 4;
    localparam int MAX_VEC      = 48;
    // valid, pc, inst, rs1, rs2, then five expected columns
    localparam int VEC_WORDS    = 10;
    localparam int MEM_WORDS    = MAX_VEC * VEC_WORDS;

    // dut inputs
    logic        sltu;
    logic        rst_n_i;
    logic        valid_i;
    logic [31:0] pc_i;
    logic [31:0] inst_i;
    logic [31:0] rs1_data_i;
    logic [31:0] rs2_data_i;
    // dut outputs
    logic [4:0]  rs1_addr_o;
    logic [4:0]  rs2_addr_o;
    logic        wb_valid_o;
    logic        wb_en_o;
    logic [4:0]  wb_addr_o;
    logic [31:0] wb_data_o;
    logic [31:0] next_pc_o;
    logic        illegal_o;

    logic [31:0] stim_mem [0:MEM_WORDS-1];
    int          num_vec;
    int          error_count;
    int          cycle_count;
    int          cycle_limit;
    // payload left on the outputs by the last valid vector
    logic        hold_data_known;
    logic [4:0]  hold_addr;
    logic [31:0] hold_data;
    logic [31:0] hold_next_pc;

    rv32i_exec_slice rv32i_exec_slice_inst (
        .sltu       (sltu),
        .rst_n_i    (rst_n_i),
        .valid_i    (valid_i),
        .pc_i       (pc_i),
        .inst_i     (inst_i),
        .rs1_data_i (rs1_data_i),
        .rs2_data_i (rs2_data_i),
        .rs1_addr_o (rs1_addr_o),
        .rs2_addr_o (rs2_addr_o),
        .wb_valid_o (wb_valid_o),
        .wb_en_o    (wb_en_o),
        .wb_addr_o  (wb_addr_o),
        .wb_data_o  (wb_data_o),
        .next_pc_o  (next_pc_o),
        .illegal_o  (illegal_o)
    );

    // 8 ns period
    initial begin
        sltu = 1'b0;
        forever #4 sltu = ~sltu;
    end

    // one column of one vector
    function automatic logic [31:0] vec_field(input int vec, input int col);
        return stim_mem[vec * VEC_WORDS + col];
    endfunction

    task automatic drive_vector(input int vec);
        valid_i    = (vec_field(vec, 0) == 32'd1);
        pc_i       = vec_field(vec, 1);
        inst_i     = vec_field(vec, 2);
        rs1_data_i = vec_field(vec, 3);
        rs2_data_i = vec_field(vec, 4);
    endtask

    // read addresses are plain instruction fields with no clock involved
    task automatic compare_read_addrs(input int vec);
        if (valid_i && (rs1_addr_o !== inst_i[19:15])) begin
            $display("FAILED rs1_addr_o vector %0d: got %h expected %h",
                     vec, rs1_addr_o, inst_i[19:15]);
            error_count++;
        end
        if (valid_i && (rs2_addr_o !== inst_i[24:20])) begin
            $display("FAILED rs2_addr_o vector %0d: got %h expected %h",
                     vec, rs2_addr_o, inst_i[24:20]);
            error_count++;
        end
    endtask

    // one result output against zero
    task automatic expect_cleared(input string name, input logic [31:0] got);
        if (got !== 32'd0) begin
            $display("FAILED %s after reset: got %h expected %h", name, got, 32'd0);
            error_count++;
        end
    endtask

    // every result output is zero once reset is released
    task automatic reset_outputs_clear();
        expect_cleared("wb_valid_o", {31'd0, wb_valid_o});
        expect_cleared("wb_en_o", {31'd0, wb_en_o});
        expect_cleared("illegal_o", {31'd0, illegal_o});
        expect_cleared("wb_addr_o", {27'd0, wb_addr_o});
        expect_cleared("wb_data_o", wb_data_o);
        expect_cleared("next_pc_o", next_pc_o);
        hold_data_known = 1'b1;
        hold_addr       = 5'd0;
        hold_data       = 32'd0;
        hold_next_pc    = 32'd0;
    endtask

    task automatic compare_results(input int vec);
        logic        exp_valid;
        logic        exp_en;
        logic        exp_ill;
        logic        data_checked;
        logic [31:0] addr_word;
        logic [4:0]  exp_addr;
        logic [31:0] exp_data;
        logic [31:0] exp_next_pc;
        exp_valid = (vec_field(vec, 0) == 32'd1);
        addr_word = vec_field(vec, 6);
        if (exp_valid) begin
            exp_en       = (vec_field(vec, 5) == 32'd1);
            exp_addr     = addr_word[4:0];
            exp_data     = vec_field(vec, 7);
            exp_next_pc  = vec_field(vec, 8);
            exp_ill      = (vec_field(vec, 9) == 32'd1);
            data_checked = exp_en;
        end else begin
            // idle cycle leaves strobes low and the payload unchanged
            exp_en       = 1'b0;
            exp_ill      = 1'b0;
            exp_addr     = hold_addr;
            exp_data     = hold_data;
            exp_next_pc  = hold_next_pc;
            data_checked = hold_data_known;
        end
        if (wb_valid_o !== exp_valid) begin
            $display("FAILED wb_valid_o vector %0d: got %h expected %h",
                     vec, wb_valid_o, exp_valid);
            error_count++;
        end
        if (wb_en_o !== exp_en) begin
            $display("FAILED wb_en_o vector %0d: got %h expected %h", vec, wb_en_o, exp_en);
            error_count++;
        end
        if (illegal_o !== exp_ill) begin
            $display("FAILED illegal_o vector %0d: got %h expected %h",
                     vec, illegal_o, exp_ill);
            error_count++;
        end
        if (next_pc_o !== exp_next_pc) begin
            $display("FAILED next_pc_o vector %0d: got %h expected %h",
                     vec, next_pc_o, exp_next_pc);
            error_count++;
        end
        // rd and data only defined when a write happens
        if (data_checked && (wb_addr_o !== exp_addr)) begin
            $display("FAILED wb_addr_o vector %0d: got %h expected %h",
                     vec, wb_addr_o, exp_addr);
            error_count++;
        end
        if (data_checked && (wb_data_o !== exp_data)) begin
            $display("FAILED wb_data_o vector %0d: got %h expected %h",
                     vec, wb_data_o, exp_data);
            error_count++;
        end
        if (exp_valid) begin
            hold_data_known = exp_en;
            hold_addr       = exp_addr;
            hold_data       = exp_data;
            hold_next_pc    = exp_next_pc;
        end
    endtask

    initial begin
        int a;
        int v;
        rst_n_i     = 1'b0;
        valid_i     = 1'b0;
        pc_i        = 32'd0;
        inst_i      = 32'd0;
        rs1_data_i  = 32'd0;
        rs2_data_i  = 32'd0;
        error_count = 0;
        cycle_count = 0;
        cycle_limit = MAX_VEC + RESET_CYCLES + 20;
        // address-tagged fill that is never a legal valid column
        for (a = 0; a < MEM_WORDS; a++) begin
            stim_mem[a] = {16'hbad0, a[15:0]};
        end
        $readmemh("testbench/exec_stim.hex", stim_mem);
        num_vec = 0;
        while (num_vec < MAX_VEC && vec_field(num_vec, 0) <= 32'd1) begin
            num_vec++;
        end
        cycle_limit = num_vec + RESET_CYCLES + 20;
        if (num_vec == 0) begin
            $display("no vectors were loaded from the stim file");
            error_count++;
        end

        // reset spans four rising edges, released on the next falling edge
        repeat (RESET_CYCLES) @(posedge sltu);
        @(negedge sltu);
        rst_n_i = 1'b1;
        reset_outputs_clear();

        // drive on the falling edge and sample one full cycle later
        for (v = 0; v < num_vec; v++) begin
            drive_vector(v);
            #1;
            compare_read_addrs(v);
            @(negedge sltu);
            compare_results(v);
        end
        valid_i = 1'b0;

        $display("summary: %0d vectors, %0d errors", num_vec, error_count);
        if (error_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // hang guard with a limit from the vector count
    always @(posedge sltu) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("timeout: run went past %0d cycles", cycle_limit);
            $display("Verification failed");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* verilog/branch_unit.sv */
// branch_unit: branch condition and next program counter
`default_nettype none
`timescale 1ns/1ps

module branch_unit (
    input  wire rv_pkg::word_t    pc_i,
    input  wire rv_pkg::word_t    rs1_data_i,
    input  wire rv_pkg::word_t    rs2_data_i,
    input  wire rv_pkg::word_t    imm_i,
    input  wire rv_pkg::br_kind_t br_kind_i,
    output rv_pkg::word_t         next_pc_o
);
    import rv_pkg::*;

    logic  eq;
    logic  lt_signed;
    logic  lt_unsigned;
    logic  taken;
    word_t seq_pc;
    word_t rel_pc;
    word_t jalr_sum;

    // rs1 against rs2
    assign eq          = (rs1_data_i == rs2_data_i);
    assign lt_signed   = $signed(rs1_data_i) < $signed(rs2_data_i);
    assign lt_unsigned = rs1_data_i < rs2_data_i;

    // candidate targets
    assign seq_pc   = pc_i + PC_STEP;
    assign rel_pc   = pc_i + imm_i;
    assign jalr_sum = rs1_data_i + imm_i;

    always_comb begin
        case (br_kind_i)
            BR_EQ:   taken = eq;
            BR_NE:   taken = !eq;
            BR_LT:   taken = lt_signed;
            BR_GE:   taken = !lt_signed;
            BR_LTU:  taken = lt_unsigned;
            BR_GEU:  taken = !lt_unsigned;
            // jal always goes pc relative
            BR_JAL:  taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    // jalr target has bit 0 forced low
    assign next_pc_o = (br_kind_i == BR_JALR) ? {jalr_sum[31:1], 1'b0} :
                       taken                  ? rel_pc : seq_pc;

endmodule

`default_nettype wire

/* verilog/execute_unit.sv */
// execute_unit: operand select and the rv32i alu
`default_nettype none
`timescale 1ns/1ps

module execute_unit (
    input  wire rv_pkg::word_t   pc_i,
    input  wire rv_pkg::word_t   rs1_data_i,
    input  wire rv_pkg::word_t   rs2_data_i,
    input  wire rv_pkg::word_t   imm_i,
    input  wire                  a_is_pc_i,
    input  wire                  b_is_imm_i,
    input  wire rv_pkg::alu_op_t alu_op_i,
    output rv_pkg::word_t        alu_result_o
);
    import rv_pkg::*;

    word_t      op_a;
    word_t      op_b;
    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    // a is pc for auipc, b is imm for i and u types
    assign op_a  = a_is_pc_i ? pc_i : rs1_data_i;
    assign op_b  = b_is_imm_i ? imm_i : rs2_data_i;
    // shifts only look at the low 5 bits
    assign shamt = op_b[4:0];

    assign lt_signed   = $signed(op_a) < $signed(op_b);
    assign lt_unsigned = op_a < op_b;

    always_comb begin
        case (alu_op_i)
            ALU_ADD:    alu_result_o = op_a + op_b;
            ALU_SUB:    alu_result_o = op_a - op_b;
            ALU_AND:    alu_result_o = op_a & op_b;
            ALU_OR:     alu_result_o = op_a | op_b;
            ALU_XOR:    alu_result_o = op_a ^ op_b;
            ALU_SLL:    alu_result_o = op_a << shamt;
            ALU_SRL:    alu_result_o = op_a >> shamt;
            // arithmetic shift keeps the sign bit
            ALU_SRA:    alu_result_o = word_t'($signed(op_a) >>> shamt);
            // set-less-than gives 0 or 1
            ALU_SLT:    alu_result_o = {31'b0, lt_signed};
            ALU_SLTU:   alu_result_o = {31'b0, lt_unsigned};
            // lui
            ALU_PASS_B: alu_result_o = op_b;
            default:    alu_result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/imm_gen.sv */
// imm_gen: sign-extended immediate for the i, b, u and j formats
`default_nettype none
`timescale 1ns/1ps

module imm_gen (
    input  wire rv_pkg::word_t   inst_i,
    input  wire rv_pkg::opcode_t opcode_i,
    output rv_pkg::word_t        imm_o
);
    import rv_pkg::*;

    word_t imm_i_fmt;
    word_t imm_b_fmt;
    word_t imm_u_fmt;
    word_t imm_j_fmt;

    // i-type, 12 bits from the top of the word
    assign imm_i_fmt = {{20{inst_i[31]}}, inst_i[31:20]};
    // b-type, offset in halfwords so bit 0 is zero
    assign imm_b_fmt = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25],
                        inst_i[11:8], 1'b0};
    // u-type, upper 20 bits
    assign imm_u_fmt = {inst_i[31:12], 12'b0};
    // j-type, 21-bit jump offset
    assign imm_j_fmt = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
                        inst_i[30:21], 1'b0};

    // format picked by opcode
    always_comb begin
        case (opcode_i)
            OPC_OP_IMM, OPC_JALR: imm_o = imm_i_fmt;
            OPC_BRANCH:           imm_o = imm_b_fmt;
            OPC_LUI, OPC_AUIPC:   imm_o = imm_u_fmt;
            OPC_JAL:              imm_o = imm_j_fmt;
            // reg-reg ops and unknown opcodes carry no immediate
            default:              imm_o = '0;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/inst_decoder.sv */
// inst_decoder: rv32i subset decode into alu, operand, next-pc and write-back controls
`default_nettype none
`timescale 1ns/1ps

module inst_decoder (
    input  wire rv_pkg::word_t inst_i,
    output rv_pkg::reg_addr_t  rs1_addr_o,
    output rv_pkg::reg_addr_t  rs2_addr_o,
    output rv_pkg::reg_addr_t  rd_addr_o,
    output rv_pkg::word_t      imm_o,
    output rv_pkg::alu_op_t    alu_op_o,
    output logic               a_is_pc_o,
    output logic               b_is_imm_o,
    output rv_pkg::br_kind_t   br_kind_o,
    output rv_pkg::wb_sel_t    wb_sel_o,
    output logic               wb_en_o,
    output logic               illegal_o
);
    import rv_pkg::*;

    opcode_t opcode;
    funct3_t funct3;
    funct7_t funct7;
    // instruction is in the kept set
    logic    legal;
    // instruction class writes rd
    logic    writes_rd;

    // fixed field positions
    assign opcode     = inst_i[6:0];
    assign funct3     = inst_i[14:12];
    assign funct7     = inst_i[31:25];
    assign rd_addr_o  = inst_i[11:7];
    assign rs1_addr_o = inst_i[19:15];
    assign rs2_addr_o = inst_i[24:20];

    imm_gen imm_gen_inst (
        .inst_i   (inst_i),
        .opcode_i (opcode),
        .imm_o    (imm_o)
    );

    always_comb begin
        // defaults describe a no-op that writes nothing
        alu_op_o   = ALU_ADD;
        a_is_pc_o  = 1'b0;
        b_is_imm_o = 1'b0;
        br_kind_o  = BR_NONE;
        wb_sel_o   = WB_ALU;
        legal      = 1'b0;
        writes_rd  = 1'b0;

        case (opcode)
            OPC_LUI: begin
                // rd = imm, passed through the alu
                alu_op_o   = ALU_PASS_B;
                b_is_imm_o = 1'b1;
                legal      = 1'b1;
                writes_rd  = 1'b1;
            end
            OPC_AUIPC: begin
                alu_op_o   = ALU_ADD;
                a_is_pc_o  = 1'b1;
                b_is_imm_o = 1'b1;
                legal      = 1'b1;
                writes_rd  = 1'b1;
            end
            OPC_OP_IMM: begin
                b_is_imm_o = 1'b1;
                writes_rd  = 1'b1;
                legal      = 1'b1;
                case (funct3)
                    F3_ADD_SUB: alu_op_o = ALU_ADD;
                    F3_SLTU:    alu_op_o = ALU_SLTU;
                    F3_XOR:     alu_op_o = ALU_XOR;
                    F3_OR:      alu_op_o = ALU_OR;
                    F3_AND:     alu_op_o = ALU_AND;
                    // shamt sits in imm[4:0], upper bits must be a valid funct7
                    F3_SLL: begin
                        alu_op_o = ALU_SLL;
                        legal    = (funct7 == F7_BASE);
                    end
                    F3_SRL_SRA: begin
                        alu_op_o = (funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
                        legal    = (funct7 == F7_BASE) || (funct7 == F7_ALT);
                    end
                    // slti is outside the kept set
                    default:    legal = 1'b0;
                endcase
            end
            OPC_OP: begin
                writes_rd = 1'b1;
                if (funct7 == F7_BASE) begin
                    legal = 1'b1;
                    case (funct3)
                        F3_ADD_SUB: alu_op_o = ALU_ADD;
                        F3_SLL:     alu_op_o = ALU_SLL;
                        F3_SLT:     alu_op_o = ALU_SLT;
                        F3_SLTU:    alu_op_o = ALU_SLTU;
                        F3_XOR:     alu_op_o = ALU_XOR;
                        F3_SRL_SRA: alu_op_o = ALU_SRL;
                        F3_OR:      alu_op_o = ALU_OR;
                        default:    alu_op_o = ALU_AND;
                    endcase
                end else if (funct7 == F7_ALT) begin
                    // only sub and sra have an alt form
                    alu_op_o = (funct3 == F3_SRL_SRA) ? ALU_SRA : ALU_SUB;
                    legal    = (funct3 == F3_ADD_SUB) || (funct3 == F3_SRL_SRA);
                end
                // anything else, e.g. the m extension, stays illegal
            end
            OPC_BRANCH: begin
                legal = 1'b1;
                case (funct3)
                    F3_BEQ:  br_kind_o = BR_EQ;
                    F3_BNE:  br_kind_o = BR_NE;
                    F3_BLT:  br_kind_o = BR_LT;
                    F3_BGE:  br_kind_o = BR_GE;
                    F3_BLTU: br_kind_o = BR_LTU;
                    F3_BGEU: br_kind_o = BR_GEU;
                    default: legal     = 1'b0;
                endcase
            end
            OPC_JAL: begin
                br_kind_o = BR_JAL;
                wb_sel_o  = WB_LINK;
                legal     = 1'b1;
                writes_rd = 1'b1;
            end
            OPC_JALR: begin
                br_kind_o = BR_JALR;
                wb_sel_o  = WB_LINK;
                legal     = (funct3 == F3_JALR);
                writes_rd = 1'b1;
            end
            default: begin
                legal = 1'b0;
            end
        endcase
    end

    // x0 is never written
    assign wb_en_o   = legal && writes_rd && (rd_addr_o != 5'd0);
    assign illegal_o = !legal;

endmodule

`default_nettype wire

/* verilog/result_stage.sv */
// result_stage: write-back data select and the registered result outputs
`default_nettype none
`timescale 1ns/1ps

module result_stage (
    input  wire                    sltu,
    input  wire                    rst_n_i,
    input  wire                    valid_i,
    input  wire                    wb_en_i,
    input  wire rv_pkg::wb_sel_t   wb_sel_i,
    input  wire rv_pkg::reg_addr_t rd_addr_i,
    input  wire rv_pkg::word_t     alu_result_i,
    input  wire rv_pkg::word_t     pc_i,
    input  wire rv_pkg::word_t     next_pc_i,
    input  wire                    illegal_i,
    output logic                   wb_valid_o,
    output logic                   wb_en_o,
    output rv_pkg::reg_addr_t      wb_addr_o,
    output rv_pkg::word_t          wb_data_o,
    output rv_pkg::word_t          next_pc_o,
    output logic                   illegal_o
);
    import rv_pkg::*;

    word_t wb_data;

    // jal and jalr write the return address
    assign wb_data = (wb_sel_i == WB_LINK) ? (pc_i + PC_STEP) : alu_result_i;

    always_ff @(posedge sltu) begin
        if (!rst_n_i) begin
            wb_valid_o <= 1'b0;
            wb_en_o    <= 1'b0;
            illegal_o  <= 1'b0;
            wb_addr_o  <= '0;
            wb_data_o  <= '0;
            next_pc_o  <= '0;
        end else begin
            // strobes drop on idle cycles
            wb_valid_o <= valid_i;
            wb_en_o    <= valid_i && wb_en_i;
            illegal_o  <= valid_i && illegal_i;
            // payload holds its last value while idle
            if (valid_i) begin
                wb_addr_o <= rd_addr_i;
                wb_data_o <= wb_data;
                next_pc_o <= next_pc_i;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/rv32i_exec_slice.sv */
// rv32i_exec_slice: top level joining decode, alu, next-pc and result register
`default_nettype none
`timescale 1ns/1ps

module rv32i_exec_slice (
    input  wire                    sltu,
    input  wire                    rst_n_i,
    input  wire                    valid_i,
    input  wire rv_pkg::word_t     pc_i,
    input  wire rv_pkg::word_t     inst_i,
    input  wire rv_pkg::word_t     rs1_data_i,
    input  wire rv_pkg::word_t     rs2_data_i,
    output rv_pkg::reg_addr_t      rs1_addr_o,
    output rv_pkg::reg_addr_t      rs2_addr_o,
    output logic                   wb_valid_o,
    output logic                   wb_en_o,
    output rv_pkg::reg_addr_t      wb_addr_o,
    output rv_pkg::word_t          wb_data_o,
    output rv_pkg::word_t          next_pc_o,
    output logic                   illegal_o
);
    import rv_pkg::*;

    // decode outputs
    reg_addr_t rd_addr;
    word_t     imm;
    alu_op_t   alu_op;
    logic      a_is_pc;
    logic      b_is_imm;
    br_kind_t  br_kind;
    wb_sel_t   wb_sel;
    logic      wb_en;
    logic      illegal;
    // execute outputs
    word_t     alu_result;
    word_t     next_pc;

    // register read addresses go out in the same cycle
    inst_decoder inst_decoder_inst (
        .inst_i     (inst_i),
        .rs1_addr_o (rs1_addr_o),
        .rs2_addr_o (rs2_addr_o),
        .rd_addr_o  (rd_addr),
        .imm_o      (imm),
        .alu_op_o   (alu_op),
        .a_is_pc_o  (a_is_pc),
        .b_is_imm_o (b_is_imm),
        .br_kind_o  (br_kind),
        .wb_sel_o   (wb_sel),
        .wb_en_o    (wb_en),
        .illegal_o  (illegal)
    );

    execute_unit execute_unit_inst (
        .pc_i         (pc_i),
        .rs1_data_i   (rs1_data_i),
        .rs2_data_i   (rs2_data_i),
        .imm_i        (imm),
        .a_is_pc_i    (a_is_pc),
        .b_is_imm_i   (b_is_imm),
        .alu_op_i     (alu_op),
        .alu_result_o (alu_result)
    );

    branch_unit branch_unit_inst (
        .pc_i       (pc_i),
        .rs1_data_i (rs1_data_i),
        .rs2_data_i (rs2_data_i),
        .imm_i      (imm),
        .br_kind_i  (br_kind),
        .next_pc_o  (next_pc)
    );

    // single register stage, results one cycle after valid_i
    result_stage result_stage_inst (
        .sltu         (sltu),
        .rst_n_i      (rst_n_i),
        .valid_i      (valid_i),
        .wb_en_i      (wb_en),
        .wb_sel_i     (wb_sel),
        .rd_addr_i    (rd_addr),
        .alu_result_i (alu_result),
        .pc_i         (pc_i),
        .next_pc_i    (next_pc),
        .illegal_i    (illegal),
        .wb_valid_o   (wb_valid_o),
        .wb_en_o      (wb_en_o),
        .wb_addr_o    (wb_addr_o),
        .wb_data_o    (wb_data_o),
        .next_pc_o    (next_pc_o),
        .illegal_o    (illegal_o)
    );

endmodule

`default_nettype wire

/* verilog/rv_pkg.sv */
// rv_pkg: word and field types, opcode, funct3 and funct7 values, alu codes, next-pc kinds
`default_nettype none

package rv_pkg;

    // data word and program counter
    typedef logic [31:0] word_t;
    // register file index
    typedef logic [4:0]  reg_addr_t;
    // instruction fields
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;
    // control field types
    typedef logic [3:0]  alu_op_t;
    // nine next-pc kinds, so one bit wider than the branch funct3
    typedef logic [3:0]  br_kind_t;
    typedef logic        wb_sel_t;

    // major opcodes of the kept rv32i subset
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;

    // funct3 for op and op-imm
    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_SLL     = 3'b001;
    localparam funct3_t F3_SLT     = 3'b010;
    localparam funct3_t F3_SLTU    = 3'b011;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_SRL_SRA = 3'b101;
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;

    // funct3 for branches and jalr
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;
    localparam funct3_t F3_JALR = 3'b000;

    // funct7, alt form selects sub and sra
    localparam funct7_t F7_BASE = 7'b0000000;
    localparam funct7_t F7_ALT  = 7'b0100000;

    // alu operation codes
    localparam alu_op_t ALU_ADD    = 4'd0;
    localparam alu_op_t ALU_SUB    = 4'd1;
    localparam alu_op_t ALU_AND    = 4'd2;
    localparam alu_op_t ALU_OR     = 4'd3;
    localparam alu_op_t ALU_XOR    = 4'd4;
    localparam alu_op_t ALU_SLL    = 4'd5;
    localparam alu_op_t ALU_SRL    = 4'd6;
    localparam alu_op_t ALU_SRA    = 4'd7;
    localparam alu_op_t ALU_SLT    = 4'd8;
    localparam alu_op_t ALU_SLTU   = 4'd9;
    localparam alu_op_t ALU_PASS_B = 4'd10;

    // next-pc kinds
    localparam br_kind_t BR_NONE = 4'd0;
    localparam br_kind_t BR_EQ   = 4'd1;
    localparam br_kind_t BR_NE   = 4'd2;
    localparam br_kind_t BR_LT   = 4'd3;
    localparam br_kind_t BR_GE   = 4'd4;
    localparam br_kind_t BR_LTU  = 4'd5;
    localparam br_kind_t BR_GEU  = 4'd6;
    localparam br_kind_t BR_JAL  = 4'd7;
    localparam br_kind_t BR_JALR = 4'd8;

    // write-back sources
    localparam wb_sel_t WB_ALU  = 1'b0;
    localparam wb_sel_t WB_LINK = 1'b1;

    // sequential pc increment
    localparam word_t PC_STEP = 32'd4;

endpackage

`default_nettype wire
